// File: s16_pkg.sv
/* Shared widths, register map and latch states for the game-board glue logic.
   Modules refer to these by scoped names. */
package s16_pkg;

    // CPU bus and register widths
    localparam int DATA_W      = 8;
    localparam int REG_ADDR_W  = 2;
    localparam int TILE_BANK_W = 6;

    // CPU-visible register map
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_CTRL      = 2'd0,
        REG_TILE_BANK = 2'd1,
        REG_SND_LATCH = 2'd2,
        REG_STATUS    = 2'd3
    } cfg_reg_e;

    // Control register bit positions
    localparam int CTRL_FLIP_BIT  = 0;
    localparam int CTRL_VIDEO_BIT = 1;
    localparam int CTRL_SOUND_BIT = 2;

    // Sound command latch occupancy
    typedef enum logic {
        LATCH_EMPTY = 1'b0,
        LATCH_FULL  = 1'b1
    } latch_state_e;

    // Control byte as seen by the CPU and the debug readout
    function automatic logic [DATA_W-1:0] ctrl_byte(
        input logic flip,
        input logic video_en,
        input logic sound_en
    );
        logic [DATA_W-1:0] b;
        b                 = '0;
        b[CTRL_FLIP_BIT]  = flip;
        b[CTRL_VIDEO_BIT] = video_en;
        b[CTRL_SOUND_BIT] = sound_en;
        return b;
    endfunction

endpackage

// File: s16_bus_if.sv
/* Main CPU register bus, bound to the top-level pins and served by the
   configuration register block. Read data follows a read by one cycle. */
`timescale 1ns/100ps

interface s16_bus_if;

    logic                             cs;
    logic                             wr;
    logic [s16_pkg::REG_ADDR_W-1:0]   addr;
    logic [s16_pkg::DATA_W-1:0]       din;
    logic [s16_pkg::DATA_W-1:0]       dout;

    // CPU side
    modport host (
        output cs, wr, addr, din,
        input  dout
    );

    // Register block side
    modport regs (
        input  cs, wr, addr, din,
        output dout
    );

endinterface

// File: s16_cen.sv
/* Clock-enable generator for CPU, pixel and sound timing.
   Each enable is a one-cycle pulse every DIV clocks. */
`timescale 1ns/100ps

module s16_cen #(
    parameter int CPU_DIV = 2,
    parameter int PXL_DIV = 4,
    parameter int SND_DIV = 8
) (
    input  logic clk,
    input  logic reset,
    output logic cpu_cen,
    output logic pxl_cen,
    output logic snd_cen
);

    localparam int NUM_CEN = 3;

    logic [NUM_CEN-1:0] cen;

    genvar i;
    generate
        for (i = 0; i < NUM_CEN; i++) begin : g_div
            // Divisor picked per slot independently of the others
            localparam int DIV   = (i == 0) ? CPU_DIV : (i == 1) ? PXL_DIV : SND_DIV;
            localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

            logic [CNT_W-1:0] cnt;

            always_ff @(posedge clk) begin
                if (reset || cnt == CNT_W'(DIV - 1)) begin
                    cnt <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end

            // Counter sits at zero in reset, so the pulse stays low
            assign cen[i] = (cnt == CNT_W'(DIV - 1));
        end
    endgenerate

    assign cpu_cen = cen[0];
    assign pxl_cen = cen[1];
    assign snd_cen = cen[2];

endmodule

// File: s16_cfg_regs.sv
/* CPU-writable board configuration: flip, video and sound enables, tile bank.
   Also forwards sound command writes and serves registered readback. */
`timescale 1ns/100ps

module s16_cfg_regs (
    input  logic                              clk,
    input  logic                              reset,
    s16_bus_if.regs                           bus,
    input  logic                              pbf,
    input  logic [s16_pkg::DATA_W-1:0]        latch_dout,
    output logic                              latch_wr,
    output logic [s16_pkg::DATA_W-1:0]        latch_data,
    output logic                              flip,
    output logic                              video_en,
    output logic                              sound_en,
    output logic [s16_pkg::TILE_BANK_W-1:0]   tile_bank
);

    s16_pkg::cfg_reg_e             reg_sel;
    logic [s16_pkg::DATA_W-1:0]    rd_data;

    assign reg_sel = s16_pkg::cfg_reg_e'(bus.addr);

    // Register writes and the latch strobe one cycle after the bus write
    always_ff @(posedge clk) begin
        if (reset) begin
            flip      <= 1'b0;
            video_en  <= 1'b0;
            sound_en  <= 1'b0;
            tile_bank <= '0;
            latch_wr  <= 1'b0;
        end else begin
            latch_wr <= 1'b0;
            if (bus.cs && bus.wr) begin
                case (reg_sel)
                    s16_pkg::REG_CTRL: begin
                        flip     <= bus.din[s16_pkg::CTRL_FLIP_BIT];
                        video_en <= bus.din[s16_pkg::CTRL_VIDEO_BIT];
                        sound_en <= bus.din[s16_pkg::CTRL_SOUND_BIT];
                    end
                    s16_pkg::REG_TILE_BANK: tile_bank <= bus.din[s16_pkg::TILE_BANK_W-1:0];
                    s16_pkg::REG_SND_LATCH: latch_wr  <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Command byte travels with the strobe
    always_ff @(posedge clk) begin
        if (bus.cs && bus.wr && reg_sel == s16_pkg::REG_SND_LATCH) begin
            latch_data <= bus.din;
        end
    end

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            s16_pkg::REG_CTRL:      rd_data = s16_pkg::ctrl_byte(flip, video_en, sound_en);
            s16_pkg::REG_TILE_BANK: rd_data[s16_pkg::TILE_BANK_W-1:0] = tile_bank;
            s16_pkg::REG_SND_LATCH: rd_data = latch_dout;
            s16_pkg::REG_STATUS:    rd_data[0] = pbf;
            default:                rd_data = '0;
        endcase
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (bus.cs && !bus.wr) begin
            bus.dout <= rd_data;
        end
    end

endmodule

// File: s16_snd_latch.sv
/* Main-to-sound command latch. Raises the sound interrupt while a command
   waits and clears it on the sound side's acknowledge. */
`timescale 1ns/100ps

module s16_snd_latch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          sound_en,
    input  logic                          latch_wr,
    input  logic [s16_pkg::DATA_W-1:0]    latch_data,
    input  logic                          snd_ack,
    output logic [s16_pkg::DATA_W-1:0]    latch_dout,
    output logic                          snd_irqn,
    output logic                          pbf
);

    s16_pkg::latch_state_e state;

    // Sound CPU held in reset while sound_en is low
    always_ff @(posedge clk) begin
        if (reset || !sound_en) begin
            state <= s16_pkg::LATCH_EMPTY;
        end else begin
            case (state)
                s16_pkg::LATCH_EMPTY: begin
                    if (latch_wr) begin
                        state <= s16_pkg::LATCH_FULL;
                    end
                end
                s16_pkg::LATCH_FULL: begin
                    // A new command overrides a simultaneous ack
                    if (!latch_wr && snd_ack) begin
                        state <= s16_pkg::LATCH_EMPTY;
                    end
                end
                default: state <= s16_pkg::LATCH_EMPTY;
            endcase
        end
    end

    // Unacknowledged commands are simply overwritten
    always_ff @(posedge clk) begin
        if (latch_wr) begin
            latch_dout <= latch_data;
        end
    end

    assign pbf      = (state == s16_pkg::LATCH_FULL);
    assign snd_irqn = ~pbf;

endmodule

// File: s16_gfx_bank.sv
/* Graphics ROM address adjust between the video renderer and memory.
   Banks and gates the object address, flips character rows. */
`timescale 1ns/100ps

module s16_gfx_bank #(
    parameter int OBJ_ADDR_W  = 16,
    parameter int CHAR_ADDR_W = 12
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       video_en,
    input  logic                                       flip,
    input  logic [s16_pkg::TILE_BANK_W-1:0]            tile_bank,
    input  logic [OBJ_ADDR_W-1:0]                      pre_obj_addr,
    input  logic                                       pre_obj_cs,
    input  logic [CHAR_ADDR_W-1:0]                     pre_char_addr,
    output logic [s16_pkg::TILE_BANK_W+OBJ_ADDR_W-1:0] obj_addr,
    output logic                                       obj_cs,
    output logic [CHAR_ADDR_W-1:0]                     char_addr
);

    // Lowest three bits select the row inside a character
    localparam int ROW_W = 3;

    always_ff @(posedge clk) begin
        if (reset) begin
            obj_cs <= 1'b0;
        end else begin
            obj_cs <= pre_obj_cs & video_en;
        end
    end

    always_ff @(posedge clk) begin
        obj_addr  <= {tile_bank, pre_obj_addr};
        char_addr <= {pre_char_addr[CHAR_ADDR_W-1:ROW_W],
                      pre_char_addr[ROW_W-1:0] ^ {ROW_W{flip}}};
    end

endmodule

// File: s16_status.sv
/* Debug readout selected by st_addr, registered one cycle.
   Unmapped addresses read as zero. */
`timescale 1ns/100ps

module s16_status (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [7:0]                        st_addr,
    input  logic                              flip,
    input  logic                              video_en,
    input  logic                              sound_en,
    input  logic [s16_pkg::TILE_BANK_W-1:0]   tile_bank,
    input  logic [s16_pkg::DATA_W-1:0]        latch_dout,
    input  logic [s16_pkg::DATA_W-1:0]        game_id,
    output logic [s16_pkg::DATA_W-1:0]        st_dout
);

    logic [s16_pkg::DATA_W-1:0] mux;

    always_comb begin
        mux = '0;
        case (st_addr[7:4])
            4'h0: mux = s16_pkg::ctrl_byte(flip, video_en, sound_en);
            4'h1: begin
                case (st_addr[3:0])
                    4'h0:    mux = latch_dout;
                    4'h1:    mux[s16_pkg::TILE_BANK_W-1:0] = tile_bank;
                    4'h2:    mux = game_id;
                    default: mux = '0;
                endcase
            end
            default: mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st_dout <= '0;
        end else begin
            st_dout <= mux;
        end
    end

endmodule

// File: s16_game.sv
/* Game-board glue top level with plain pins for the CPU, sound, video and debug
   sides. Sets the divider and address-width parameters for the blocks below. */
`timescale 1ns/100ps

module s16_game #(
    parameter int CPU_DIV     = 2,
    parameter int PXL_DIV     = 4,
    parameter int SND_DIV     = 8,
    parameter int OBJ_ADDR_W  = 16,
    parameter int CHAR_ADDR_W = 12
) (
    input  logic                                       clk,
    input  logic                                       reset,
    // Main CPU bus
    input  logic                                       cpu_cs,
    input  logic                                       cpu_wr,
    input  logic [s16_pkg::REG_ADDR_W-1:0]             cpu_addr,
    input  logic [s16_pkg::DATA_W-1:0]                 cpu_din,
    output logic [s16_pkg::DATA_W-1:0]                 cpu_dout,
    input  logic [s16_pkg::DATA_W-1:0]                 game_id,
    // Sound CPU side
    input  logic                                       snd_ack,
    output logic [s16_pkg::DATA_W-1:0]                 snd_latch,
    output logic                                       snd_irqn,
    // Graphics ROM addresses before and after adjust
    input  logic [OBJ_ADDR_W-1:0]                      pre_obj_addr,
    input  logic                                       pre_obj_cs,
    input  logic [CHAR_ADDR_W-1:0]                     pre_char_addr,
    output logic [s16_pkg::TILE_BANK_W+OBJ_ADDR_W-1:0] obj_addr,
    output logic                                       obj_cs,
    output logic [CHAR_ADDR_W-1:0]                     char_addr,
    // Debug readout
    input  logic [7:0]                                 st_addr,
    output logic [s16_pkg::DATA_W-1:0]                 st_dout,
    // Clock enables
    output logic                                       cpu_cen,
    output logic                                       pxl_cen,
    output logic                                       snd_cen
);

    logic                              latch_wr;
    logic [s16_pkg::DATA_W-1:0]        latch_data;
    logic [s16_pkg::DATA_W-1:0]        latch_dout;
    logic                              pbf;
    logic                              flip, video_en, sound_en;
    logic [s16_pkg::TILE_BANK_W-1:0]   tile_bank;

    s16_bus_if bus ();

    // CPU pins onto the register bus
    assign bus.cs   = cpu_cs;
    assign bus.wr   = cpu_wr;
    assign bus.addr = cpu_addr;
    assign bus.din  = cpu_din;
    assign cpu_dout = bus.dout;

    assign snd_latch = latch_dout;

    s16_cen #(
        .CPU_DIV    ( CPU_DIV   ),
        .PXL_DIV    ( PXL_DIV   ),
        .SND_DIV    ( SND_DIV   )
    ) u_cen (
        .clk        ( clk       ),
        .reset      ( reset     ),
        .cpu_cen    ( cpu_cen   ),
        .pxl_cen    ( pxl_cen   ),
        .snd_cen    ( snd_cen   )
    );

    s16_cfg_regs u_regs (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .bus        ( bus        ),
        .pbf        ( pbf        ),
        .latch_dout ( latch_dout ),
        .latch_wr   ( latch_wr   ),
        .latch_data ( latch_data ),
        .flip       ( flip       ),
        .video_en   ( video_en   ),
        .sound_en   ( sound_en   ),
        .tile_bank  ( tile_bank  )
    );

    s16_snd_latch u_latch (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sound_en   ( sound_en   ),
        .latch_wr   ( latch_wr   ),
        .latch_data ( latch_data ),
        .snd_ack    ( snd_ack    ),
        .latch_dout ( latch_dout ),
        .snd_irqn   ( snd_irqn   ),
        .pbf        ( pbf        )
    );

    s16_gfx_bank #(
        .OBJ_ADDR_W    ( OBJ_ADDR_W    ),
        .CHAR_ADDR_W   ( CHAR_ADDR_W   )
    ) u_gfx (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .video_en      ( video_en      ),
        .flip          ( flip          ),
        .tile_bank     ( tile_bank     ),
        .pre_obj_addr  ( pre_obj_addr  ),
        .pre_obj_cs    ( pre_obj_cs    ),
        .pre_char_addr ( pre_char_addr ),
        .obj_addr      ( obj_addr      ),
        .obj_cs        ( obj_cs        ),
        .char_addr     ( char_addr     )
    );

    s16_status u_status (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .st_addr    ( st_addr    ),
        .flip       ( flip       ),
        .video_en   ( video_en   ),
        .sound_en   ( sound_en   ),
        .tile_bank  ( tile_bank  ),
        .latch_dout ( latch_dout ),
        .game_id    ( game_id    ),
        .st_dout    ( st_dout    )
    );

endmodule

// File: tb_s16_game.sv
/* Random-stimulus testbench for the game-board glue top level. Drives the CPU bus,
   sound ack, graphics and debug pins and checks every output against a cycle model. */
`timescale 1ns/100ps

module tb_s16_game;

    localparam int CPU_DIV        = 2;
    localparam int PXL_DIV        = 4;
    localparam int SND_DIV        = 8;
    localparam int OBJ_W          = 16;
    localparam int CHAR_W         = 12;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_OPS        = 600;
    localparam int MAX_OP_CYCLES  = 6;
    localparam int CEN_WINDOW     = 240;
    // Reset, every op at its longest, then margin for the drain
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * MAX_OP_CYCLES + 390;

    logic              clk;
    logic              reset;
    logic              cpu_cs;
    logic              cpu_wr;
    logic [1:0]        cpu_addr;
    logic [7:0]        cpu_din;
    logic [7:0]        cpu_dout;
    logic [7:0]        game_id;
    logic              snd_ack;
    logic [7:0]        snd_latch;
    logic              snd_irqn;
    logic [OBJ_W-1:0]  pre_obj_addr;
    logic              pre_obj_cs;
    logic [CHAR_W-1:0] pre_char_addr;
    logic [OBJ_W+5:0]  obj_addr;
    logic              obj_cs;
    logic [CHAR_W-1:0] char_addr;
    logic [7:0]        st_addr;
    logic [7:0]        st_dout;
    logic              cpu_cen;
    logic              pxl_cen;
    logic              snd_cen;

    logic [31:0]       lcg_state;
    int                cycle_count = 0;
    int                check_count = 0;
    int                err_count = 0;
    bit                model_live = 1'b0;
    int                win_cycles = 0;
    int                cpu_pulses = 0;
    int                pxl_pulses = 0;
    int                snd_pulses = 0;

    // Model state as the DUT holds it after each rising edge
    logic              m_flip;
    logic              m_video;
    logic              m_sound;
    logic [5:0]        m_bank;
    logic              m_latch_wr;
    logic [7:0]        m_latch_data;
    logic              m_full;
    logic [7:0]        m_latch_dout;
    logic [7:0]        m_cpu_dout;
    logic [OBJ_W+5:0]  m_obj_addr;
    logic              m_obj_cs;
    logic [CHAR_W-1:0] m_char_addr;
    logic [7:0]        m_st_dout;

    s16_game #(
        .CPU_DIV       ( CPU_DIV       ),
        .PXL_DIV       ( PXL_DIV       ),
        .SND_DIV       ( SND_DIV       ),
        .OBJ_ADDR_W    ( OBJ_W         ),
        .CHAR_ADDR_W   ( CHAR_W        )
    ) UUT (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .cpu_cs        ( cpu_cs        ),
        .cpu_wr        ( cpu_wr        ),
        .cpu_addr      ( cpu_addr      ),
        .cpu_din       ( cpu_din       ),
        .cpu_dout      ( cpu_dout      ),
        .game_id       ( game_id       ),
        .snd_ack       ( snd_ack       ),
        .snd_latch     ( snd_latch     ),
        .snd_irqn      ( snd_irqn      ),
        .pre_obj_addr  ( pre_obj_addr  ),
        .pre_obj_cs    ( pre_obj_cs    ),
        .pre_char_addr ( pre_char_addr ),
        .obj_addr      ( obj_addr      ),
        .obj_cs        ( obj_cs        ),
        .char_addr     ( char_addr     ),
        .st_addr       ( st_addr       ),
        .st_dout       ( st_dout       ),
        .cpu_cen       ( cpu_cen       ),
        .pxl_cen       ( pxl_cen       ),
        .snd_cen       ( snd_cen       )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Upper half of the LCG state since the low bits repeat too quickly
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic rand_ack();
        logic [15:0] r;
        r = next_rand();
        return (r[15:13] == 3'd0);
    endfunction

    // Biased towards the mapped debug addresses
    function automatic logic [7:0] pick_status_addr();
        logic [15:0] r;
        r = next_rand();
        case (r[15:14])
            2'd0:    return {4'h0, r[3:0]};
            2'd1:    return {4'h1, 2'b00, r[1:0]};
            2'd2:    return {4'h1, 2'b00, r[1:0]};
            default: return r[7:0];
        endcase
    endfunction

    function automatic logic [7:0] ctrl_value();
        return {5'b00000, m_sound, m_video, m_flip};
    endfunction

    function automatic logic [7:0] read_value(input logic [1:0] addr);
        case (addr)
            2'd0:    return ctrl_value();
            2'd1:    return {2'b00, m_bank};
            2'd2:    return m_latch_dout;
            default: return {7'b0000000, m_full};
        endcase
    endfunction

    function automatic logic [7:0] status_value(input logic [7:0] addr);
        if (addr[7:4] == 4'h0) begin
            return ctrl_value();
        end else if (addr[7:4] == 4'h1 && addr[3:0] == 4'h0) begin
            return m_latch_dout;
        end else if (addr[7:4] == 4'h1 && addr[3:0] == 4'h1) begin
            return {2'b00, m_bank};
        end else if (addr[7:4] == 4'h1 && addr[3:0] == 4'h2) begin
            return game_id;
        end
        return 8'h00;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One bus cycle plus fresh random graphics and debug inputs
    task automatic bus_cycle(input logic cs, input logic wr, input logic [1:0] addr,
                             input logic [7:0] din, input logic ack);
        logic [15:0] obj_r;
        logic [15:0] char_r;
        logic [7:0]  st_r;
        obj_r  = next_rand();
        char_r = next_rand();
        st_r   = pick_status_addr();
        @(posedge clk);
        cpu_cs        <= cs;
        cpu_wr        <= wr;
        cpu_addr      <= addr;
        cpu_din       <= din;
        snd_ack       <= ack;
        pre_obj_addr  <= obj_r;
        pre_obj_cs    <= char_r[0];
        pre_char_addr <= char_r[15:4];
        st_addr       <= st_r;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (reset) begin
            model_live = 1'b0;
            m_flip     = 1'b0;
            m_video    = 1'b0;
            m_sound    = 1'b0;
            m_bank     = '0;
            m_latch_wr = 1'b0;
            m_full     = 1'b0;
            m_obj_cs   = 1'b0;
            m_st_dout  = 8'h00;
        end else begin
            model_live = 1'b1;
            // Registered outputs see the state from before this edge
            if (cpu_cs && !cpu_wr) begin
                m_cpu_dout = read_value(cpu_addr);
            end
            m_obj_addr  = {m_bank, pre_obj_addr};
            m_obj_cs    = pre_obj_cs & m_video;
            m_char_addr = m_flip ? (pre_char_addr ^ CHAR_W'(7)) : pre_char_addr;
            m_st_dout   = status_value(st_addr);
            // Latch where a new command wins over an ack
            if (!m_sound) begin
                m_full = 1'b0;
            end else if (m_latch_wr) begin
                m_full = 1'b1;
            end else if (snd_ack) begin
                m_full = 1'b0;
            end
            if (m_latch_wr) begin
                m_latch_dout = m_latch_data;
            end
            // Register writes
            m_latch_wr = cpu_cs && cpu_wr && cpu_addr == 2'd2;
            if (m_latch_wr) begin
                m_latch_data = cpu_din;
            end
            if (cpu_cs && cpu_wr && cpu_addr == 2'd0) begin
                m_flip  = cpu_din[0];
                m_video = cpu_din[1];
                m_sound = cpu_din[2];
            end
            if (cpu_cs && cpu_wr && cpu_addr == 2'd1) begin
                m_bank = cpu_din[5:0];
            end
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            if (cycle_count > 0) begin
                check_value("cpu_cen in reset", 32'(cpu_cen), 32'd0);
                check_value("pxl_cen in reset", 32'(pxl_cen), 32'd0);
                check_value("snd_cen in reset", 32'(snd_cen), 32'd0);
                check_value("snd_irqn in reset", 32'(snd_irqn), 32'd1);
                check_value("obj_cs in reset", 32'(obj_cs), 32'd0);
            end
        end else if (model_live) begin
            check_value("cpu_dout", 32'(cpu_dout), 32'(m_cpu_dout));
            check_value("snd_irqn", 32'(snd_irqn), 32'(!m_full));
            check_value("snd_latch", 32'(snd_latch), 32'(m_latch_dout));
            check_value("obj_addr", 32'(obj_addr), 32'(m_obj_addr));
            check_value("obj_cs", 32'(obj_cs), 32'(m_obj_cs));
            check_value("char_addr", 32'(char_addr), 32'(m_char_addr));
            check_value("st_dout", 32'(st_dout), 32'(m_st_dout));
            if (win_cycles < CEN_WINDOW) begin
                win_cycles++;
                cpu_pulses += int'(cpu_cen);
                pxl_pulses += int'(pxl_cen);
                snd_pulses += int'(snd_cen);
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [15:0] sel;
        logic [15:0] r;
        int          op;
        reset         <= 1'b1;
        cpu_cs        <= 1'b0;
        cpu_wr        <= 1'b0;
        cpu_addr      <= 2'd0;
        cpu_din       <= 8'h00;
        snd_ack       <= 1'b0;
        pre_obj_addr  <= '0;
        pre_obj_cs    <= 1'b0;
        pre_char_addr <= '0;
        st_addr       <= 8'h00;
        lcg_state = 32'd14959;
        r = next_rand();
        game_id       <= r[7:0];
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (op = 0; op < NUM_OPS; op++) begin
            sel = next_rand();
            r   = next_rand();
            case (sel[15:13])
                3'd0, 3'd1: begin
                    bus_cycle(1'b1, 1'b1, s16_pkg::REG_CTRL, r[7:0], rand_ack());
                    bus_cycle(1'b1, 1'b0, s16_pkg::REG_CTRL, 8'h00, rand_ack());
                end
                3'd2: begin
                    bus_cycle(1'b1, 1'b1, s16_pkg::REG_TILE_BANK, r[7:0], rand_ack());
                    bus_cycle(1'b1, 1'b0, s16_pkg::REG_TILE_BANK, 8'h00, rand_ack());
                end
                3'd3, 3'd4: begin
                    // Command, status with pbf, ack, status again
                    bus_cycle(1'b1, 1'b1, s16_pkg::REG_SND_LATCH, r[7:0], 1'b0);
                    bus_cycle(1'b0, 1'b0, 2'd0, 8'h00, 1'b0);
                    bus_cycle(1'b1, 1'b0, s16_pkg::REG_STATUS, 8'h00, 1'b0);
                    bus_cycle(1'b0, 1'b0, 2'd0, 8'h00, 1'b1);
                    bus_cycle(1'b1, 1'b0, s16_pkg::REG_STATUS, 8'h00, 1'b0);
                end
                3'd5: bus_cycle(1'b1, 1'b0, r[1:0], 8'h00, rand_ack());
                default: bus_cycle(1'b0, 1'b0, 2'd0, 8'h00, rand_ack());
            endcase
            if (sel[0]) begin
                bus_cycle(1'b0, 1'b0, 2'd0, 8'h00, rand_ack());
            end
        end
        repeat (3) bus_cycle(1'b0, 1'b0, 2'd0, 8'h00, 1'b0);
        @(negedge clk);

        check_value("cpu_cen pulses", 32'(cpu_pulses), 32'(CEN_WINDOW / CPU_DIV));
        check_value("pxl_cen pulses", 32'(pxl_pulses), 32'(CEN_WINDOW / PXL_DIV));
        check_value("snd_cen pulses", 32'(snd_pulses), 32'(CEN_WINDOW / SND_DIV));

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: s16_game.f
s16_pkg.sv
s16_bus_if.sv
s16_cen.sv
s16_cfg_regs.sv
s16_snd_latch.sv
s16_gfx_bank.sv
s16_status.sv
s16_game.sv
tb_s16_game.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_s16_game -f s16_game.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_s16_game > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
